// File: src.f
hdl/pad_ctrl_pkg.sv
hdl/pad_cfg_regs.sv
hdl/spi_pad_dir.sv
hdl/pad_drive_mux.sv
hdl/pad_in_route.sv
hdl/pad_ctrl_top.sv
bench/pad_ctrl_chk.sv
bench/pad_ctrl_tb.sv

// File: Makefile
# Verilator build and run for the SPI pad controller testbench

TOP      ?= pad_ctrl_tb
SRC      ?= src.f
VFLAGS   ?= --binary --timing --assert -j 0
OBJ_DIR  ?= obj_dir
PASS_MSG ?= ALL CHECKS PASSED

.PHONY: sim clean

sim:
	verilator $(VFLAGS) --top-module $(TOP) -f $(SRC) --Mdir $(OBJ_DIR)
	out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: bench/pad_ctrl_tb.sv
// Testbench for the SPI pad controller
// Drives the AXI4-Lite bus and all pad side sources, keeps a shadow of
// the registers and compares every output with a reference model.

`timescale 1ns/1ps

module pad_ctrl_tb;

   typedef struct packed {
      pad_ctrl_pkg::pad_drive_t                            drive;
      pad_ctrl_pkg::pad_cfg_t [pad_ctrl_pkg::NUM_PADS-1:0] cfg;
      pad_ctrl_pkg::pad_vec_t                              gpio_in;
      logic [3:0]                                          sdi;
      logic                                                sda_in;
      logic                                                scl_in;
   } expect_t;

   // Rough cycle budget of the five tests
   localparam int TEST_CYCLES = 10 + 20 + 100 + 40 + 160;
   localparam int TIMEOUT     = 4 * TEST_CYCLES;
   localparam logic [3:0] SDIO_OE [4] = '{4'b0001, 4'b0000, 4'b1111, 4'b0000};

   logic                                                clk = 1'b0;
   logic                                                reset;
   pad_ctrl_pkg::axil_req_t                             req;
   pad_ctrl_pkg::axil_rsp_t                             rsp;
   pad_ctrl_pkg::spim_tx_t                              spim;
   logic [3:0]                                          spim_sdi;
   pad_ctrl_pkg::pad_vec_t                              gpio_out;
   pad_ctrl_pkg::pad_vec_t                              gpio_dir;
   pad_ctrl_pkg::pad_cfg_t [pad_ctrl_pkg::NUM_PADS-1:0] gpio_cfg;
   pad_ctrl_pkg::pad_vec_t                              gpio_in;
   logic                                                sda_out;
   logic                                                sda_oe;
   logic                                                scl_out;
   logic                                                scl_oe;
   logic                                                sda_in;
   logic                                                scl_in;
   pad_ctrl_pkg::pad_vec_t                              pad_in;
   pad_ctrl_pkg::pad_drive_t                            pad_drive;
   pad_ctrl_pkg::pad_cfg_t [pad_ctrl_pkg::NUM_PADS-1:0] pad_cfg;

   // Register shadow
   logic [2*pad_ctrl_pkg::NUM_PADS-1:0]                 fn_shadow;
   pad_ctrl_pkg::pad_cfg_t [pad_ctrl_pkg::NUM_PADS-1:0] cfg_shadow;

   logic [31:0] rng_state = 32'd995;
   logic        cmp_en = 1'b0;
   string       cur_test;
   int          cycle_count = 0;
   int          checks = 0;
   int          errors = 0;
   int          err_at_start;
   int          tests_run = 0;
   int          tests_failed = 0;

   always #10 clk = ~clk;

   pad_ctrl_top u_dut (
      .clk_i          (clk),
      .reset_i        (reset),
      .axil_req_i     (req),
      .axil_rsp_o     (rsp),
      .spim_i         (spim),
      .spim_sdi_o     (spim_sdi),
      .gpio_out_i     (gpio_out),
      .gpio_dir_i     (gpio_dir),
      .gpio_cfg_i     (gpio_cfg),
      .gpio_in_o      (gpio_in),
      .i2c1_sda_out_i (sda_out),
      .i2c1_sda_oe_i  (sda_oe),
      .i2c1_scl_out_i (scl_out),
      .i2c1_scl_oe_i  (scl_oe),
      .i2c1_sda_in_o  (sda_in),
      .i2c1_scl_in_o  (scl_in),
      .pad_in_i       (pad_in),
      .pad_drive_o    (pad_drive),
      .pad_cfg_o      (pad_cfg)
   );

   function automatic logic [31:0] next_random();
      rng_state = rng_state ^ (rng_state << 13);
      rng_state = rng_state ^ (rng_state >> 17);
      rng_state = rng_state ^ (rng_state << 5);
      return rng_state;
   endfunction

   task automatic check(input string what, input logic [63:0] exp, input logic [63:0] act);
      checks++;
      if (exp !== act)
      begin
         errors++;
         $display("Mismatch in %s, %s: expected 0x%0h, actual 0x%0h", cur_test, what, exp, act);
      end
   endtask

   ////////////////////////////////////////////////////////////
   // Reference model
   ////////////////////////////////////////////////////////////
   function automatic expect_t expected_outputs();
      expect_t               e;
      pad_ctrl_pkg::pad_fn_t fn;
      e = '0;
      for (int n = 0; n < pad_ctrl_pkg::NUM_PADS; n++)
      begin
         fn = fn_shadow[2*n +: 2];
         e.cfg[n]     = (fn == pad_ctrl_pkg::FN_GPIO) ? gpio_cfg[n] : cfg_shadow[n];
         e.gpio_in[n] = (fn == pad_ctrl_pkg::FN_GPIO) & pad_in[n];
         case (fn)
            pad_ctrl_pkg::FN_PERIPH:
            begin
               if (n == pad_ctrl_pkg::PAD_CSN0)
               begin
                  e.drive.out[n] = spim.csn0;
                  e.drive.oe[n]  = 1'b1;
               end
               else if (n == pad_ctrl_pkg::PAD_SCK)
               begin
                  e.drive.out[n] = spim.sck;
                  e.drive.oe[n]  = 1'b1;
               end
               else
               begin
                  e.drive.out[n] = spim.sdo[n];
                  e.drive.oe[n]  = (spim.mode == pad_ctrl_pkg::SPI_QUAD_TX) ||
                                   (spim.mode == pad_ctrl_pkg::SPI_STD_TX && n == 0);
               end
            end
            pad_ctrl_pkg::FN_GPIO:
            begin
               e.drive.out[n] = gpio_out[n];
               e.drive.oe[n]  = gpio_dir[n];
            end
            pad_ctrl_pkg::FN_ALT:
            begin
               // I2C1 SDA on sdio2, SCL on sdio3, others drive 0
               if (n == pad_ctrl_pkg::PAD_SDIO2)
               begin
                  e.drive.out[n] = sda_out;
                  e.drive.oe[n]  = sda_oe;
               end
               else if (n == pad_ctrl_pkg::PAD_SDIO3)
               begin
                  e.drive.out[n] = scl_out;
                  e.drive.oe[n]  = scl_oe;
               end
               else
                  e.drive.oe[n] = 1'b1;
            end
            default:
               e.drive.oe[n] = 1'b0;
         endcase
      end
      if (spim.mode == pad_ctrl_pkg::SPI_QUAD_RX)
         e.sdi[0] = (fn_shadow[1:0] == pad_ctrl_pkg::FN_PERIPH) & pad_in[0];
      else
         e.sdi[0] = (fn_shadow[3:2] == pad_ctrl_pkg::FN_PERIPH) & pad_in[1];
      for (int n = 1; n < 4; n++)
      begin
         e.sdi[n] = (fn_shadow[2*n +: 2] == pad_ctrl_pkg::FN_PERIPH) & pad_in[n];
      end
      e.sda_in = (fn_shadow[5:4] == pad_ctrl_pkg::FN_ALT) ? pad_in[2] : 1'b1;
      e.scl_in = (fn_shadow[7:6] == pad_ctrl_pkg::FN_ALT) ? pad_in[3] : 1'b1;
      return e;
   endfunction

   function automatic logic addr_mapped(input pad_ctrl_pkg::axil_addr_t addr);
      logic hit;
      hit = (addr == pad_ctrl_pkg::ADDR_FN);
      for (int n = 0; n < pad_ctrl_pkg::NUM_PADS; n++)
      begin
         hit = hit | (addr == pad_ctrl_pkg::axil_addr_t'(pad_ctrl_pkg::ADDR_CFG0 + 4 * n));
      end
      return hit;
   endfunction

   function automatic pad_ctrl_pkg::axil_data_t expected_read(
      input pad_ctrl_pkg::axil_addr_t addr);
      pad_ctrl_pkg::axil_data_t d;
      d = '0;
      if (addr == pad_ctrl_pkg::ADDR_FN)
         d = pad_ctrl_pkg::axil_data_t'(fn_shadow);
      for (int n = 0; n < pad_ctrl_pkg::NUM_PADS; n++)
      begin
         if (addr == pad_ctrl_pkg::axil_addr_t'(pad_ctrl_pkg::ADDR_CFG0 + 4 * n))
            d = pad_ctrl_pkg::axil_data_t'(cfg_shadow[n]);
      end
      return d;
   endfunction

   // Compare process, one sample per cycle on the falling edge
   always @(negedge clk)
   begin
      expect_t e;
      if (cmp_en && !reset)
      begin
         e = expected_outputs();
         check("pad_out", 64'(e.drive.out), 64'(pad_drive.out));
         check("pad_oe", 64'(e.drive.oe), 64'(pad_drive.oe));
         check("pad_cfg", 64'(e.cfg), 64'(pad_cfg));
         check("gpio_in", 64'(e.gpio_in), 64'(gpio_in));
         check("spim_sdi", 64'(e.sdi), 64'(spim_sdi));
         check("i2c1_in", 64'({e.sda_in, e.scl_in}), 64'({sda_in, scl_in}));
      end
   end

   always @(posedge clk)
   begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= TIMEOUT)
      begin
         $display("Timeout after %0d cycles in test %s", cycle_count, cur_test);
         $display("CHECKS FAILED");
         $finish;
      end
   end

   ////////////////////////////////////////////////////////////
   // Bus tasks
   ////////////////////////////////////////////////////////////
   task automatic bus_write(input pad_ctrl_pkg::axil_addr_t addr,
                            input pad_ctrl_pkg::axil_data_t data,
                            input int hold, output logic [1:0] resp);
      @(posedge clk);
      cmp_en = 1'b0;
      req.awvalid <= 1'b1;
      req.awaddr  <= addr;
      req.wvalid  <= 1'b1;
      req.wdata   <= data;
      req.bready  <= (hold == 0);
      do @(negedge clk); while (!rsp.awready);
      check("wready", 64'(1), 64'(rsp.wready));
      @(posedge clk);
      req.awvalid <= 1'b0;
      req.wvalid  <= 1'b0;
      do @(negedge clk); while (!rsp.bvalid);
      resp = rsp.bresp;
      repeat (hold)
      begin
         @(negedge clk);
         check("bvalid_held", 64'(1), 64'(rsp.bvalid));
      end
      if (hold > 0)
      begin
         @(posedge clk);
         req.bready <= 1'b1;
      end
      @(posedge clk);
      req.bready <= 1'b0;
   endtask

   task automatic bus_read(input pad_ctrl_pkg::axil_addr_t addr,
                           output pad_ctrl_pkg::axil_data_t data, output logic [1:0] resp);
      @(posedge clk);
      cmp_en = 1'b0;
      req.arvalid <= 1'b1;
      req.araddr  <= addr;
      req.rready  <= 1'b1;
      do @(negedge clk); while (!rsp.arready);
      @(posedge clk);
      req.arvalid <= 1'b0;
      do @(negedge clk); while (!rsp.rvalid);
      data = rsp.rdata;
      resp = rsp.rresp;
      @(posedge clk);
      req.rready <= 1'b0;
   endtask

   task automatic reg_write(input pad_ctrl_pkg::axil_addr_t addr,
                            input pad_ctrl_pkg::axil_data_t data, input int hold);
      logic [1:0] resp;
      bus_write(addr, data, hold, resp);
      check("bresp", 64'(addr_mapped(addr) ? pad_ctrl_pkg::RESP_OKAY : pad_ctrl_pkg::RESP_SLVERR),
            64'(resp));
      if (addr == pad_ctrl_pkg::ADDR_FN)
         fn_shadow = data[2*pad_ctrl_pkg::NUM_PADS-1:0];
      for (int n = 0; n < pad_ctrl_pkg::NUM_PADS; n++)
      begin
         if (addr == pad_ctrl_pkg::axil_addr_t'(pad_ctrl_pkg::ADDR_CFG0 + 4 * n))
            cfg_shadow[n] = data[5:0];
      end
      cmp_en = 1'b1;
   endtask

   task automatic reg_read(input pad_ctrl_pkg::axil_addr_t addr);
      pad_ctrl_pkg::axil_data_t data;
      logic [1:0]               resp;
      bus_read(addr, data, resp);
      check("rresp", 64'(addr_mapped(addr) ? pad_ctrl_pkg::RESP_OKAY : pad_ctrl_pkg::RESP_SLVERR),
            64'(resp));
      check("rdata", 64'(expected_read(addr)), 64'(data));
      cmp_en = 1'b1;
   endtask

   // New random pad side inputs, returns on the falling edge after
   task automatic randomize_inputs(input pad_ctrl_pkg::spi_mode_t mode);
      logic [31:0] r;
      @(posedge clk);
      r = next_random();
      spim     <= pad_ctrl_pkg::spim_tx_t'({r[5:0], mode});
      gpio_out <= r[11:6];
      gpio_dir <= r[17:12];
      pad_in   <= r[23:18];
      {sda_out, sda_oe, scl_out, scl_oe} <= r[27:24];
      gpio_cfg <= 36'({next_random(), next_random()});
      @(negedge clk);
   endtask

   task automatic test_begin(input string name);
      cur_test     = name;
      err_at_start = errors;
      tests_run++;
   endtask

   task automatic test_end();
      if (errors == err_at_start)
         $display("Test %s: pass", cur_test);
      else
      begin
         tests_failed++;
         $display("Test %s: fail with %0d errors", cur_test, errors - err_at_start);
      end
   endtask

   ////////////////////////////////////////////////////////////
   // Test sequence
   ////////////////////////////////////////////////////////////
   initial
   begin
      pad_ctrl_pkg::axil_addr_t addr;
      int                       idx;
      reset      = 1'b1;
      req        = '0;
      spim       = '0;
      gpio_out   = '0;
      gpio_dir   = '0;
      gpio_cfg   = '0;
      sda_out    = 1'b0;
      sda_oe     = 1'b0;
      scl_out    = 1'b0;
      scl_oe     = 1'b0;
      pad_in     = '0;
      fn_shadow  = '0;
      cfg_shadow = '0;
      cur_test   = "reset";
      repeat (4) @(posedge clk);
      reset <= 1'b0;
      cmp_en = 1'b1;

      test_begin("reset_state");
      reg_read(pad_ctrl_pkg::ADDR_FN);
      randomize_inputs(pad_ctrl_pkg::SPI_STD_TX);
      check("csn_sck_oe", 64'(2'b11), 64'(pad_drive.oe[5:4]));
      test_end();

      test_begin("spi_modes");
      for (int m = 0; m < 4; m++)
      begin
         repeat (4)
         begin
            randomize_inputs(pad_ctrl_pkg::spi_mode_t'(m));
            check("sdio_oe", 64'(SDIO_OE[m]), 64'(pad_drive.oe[3:0]));
            check("sdi0_pad", 64'((m == 3) ? pad_in[0] : pad_in[1]), 64'(spim_sdi[0]));
         end
      end
      test_end();

      test_begin("gpio_function");
      repeat (16)
      begin
         reg_write(pad_ctrl_pkg::ADDR_FN, next_random(), 0);
         randomize_inputs(pad_ctrl_pkg::spi_mode_t'(next_random()));
      end
      test_end();

      test_begin("alt_and_unused");
      reg_write(pad_ctrl_pkg::ADDR_FN, 32'haaa, 0);
      repeat (4)
      begin
         randomize_inputs(pad_ctrl_pkg::spi_mode_t'(next_random()));
         check("i2c1_sda_in", 64'(pad_in[2]), 64'(sda_in));
      end
      reg_write(pad_ctrl_pkg::ADDR_FN, 32'hfff, 0);
      repeat (4)
      begin
         randomize_inputs(pad_ctrl_pkg::spi_mode_t'(next_random()));
         check("none_out", 64'(0), 64'(pad_drive.out));
         check("none_oe", 64'(0), 64'(pad_drive.oe));
      end
      repeat (4)
      begin
         reg_write(pad_ctrl_pkg::ADDR_FN, next_random(), 0);
         randomize_inputs(pad_ctrl_pkg::spi_mode_t'(next_random()));
      end
      test_end();

      test_begin("register_access");
      repeat (12)
      begin
         idx = int'(next_random() % 7);
         if (idx == 0)
            addr = pad_ctrl_pkg::ADDR_FN;
         else
            addr = pad_ctrl_pkg::axil_addr_t'(pad_ctrl_pkg::ADDR_CFG0 + 4 * (idx - 1));
         reg_write(addr, next_random(), 0);
         reg_read(addr);
      end
      for (int n = 0; n < pad_ctrl_pkg::NUM_PADS; n++)
      begin
         reg_read(pad_ctrl_pkg::axil_addr_t'(pad_ctrl_pkg::ADDR_CFG0 + 4 * n));
      end
      reg_read(8'h08);
      reg_read(8'h30);
      reg_write(8'h44, next_random(), 0);
      reg_write(pad_ctrl_pkg::ADDR_CFG0, next_random(), 3);
      reg_read(pad_ctrl_pkg::ADDR_CFG0);
      test_end();

      @(posedge clk);
      $display("Tests: %0d run, %0d failed. Checks: %0d, errors: %0d",
               tests_run, tests_failed, checks, errors);
      if (errors == 0)
         $display("ALL CHECKS PASSED");
      else
         $display("CHECKS FAILED");
      $finish;
   end

endmodule

// File: bench/pad_ctrl_chk.sv
// Protocol and pad safety checker for the pad controller
// Bound to the top level, flags dropped bus responses and
// any unused pad that drives its output.

`timescale 1ns/1ps

module pad_ctrl_chk (
   input logic                                               clk_i,
   input logic                                               reset_i,
   input pad_ctrl_pkg::axil_req_t                            req_i,
   input pad_ctrl_pkg::axil_rsp_t                            rsp_i,
   input pad_ctrl_pkg::pad_fn_t [pad_ctrl_pkg::NUM_PADS-1:0] pad_fn_i,
   input pad_ctrl_pkg::pad_drive_t                           drive_i
);

   pad_ctrl_pkg::pad_vec_t none_oe;

   always_comb
   begin
      for (int n = 0; n < pad_ctrl_pkg::NUM_PADS; n++)
      begin
         none_oe[n] = (pad_fn_i[n] == pad_ctrl_pkg::FN_NONE) & drive_i.oe[n];
      end
   end

   bvalid_hold: assert property (@(posedge clk_i) disable iff (reset_i)
      rsp_i.bvalid && !req_i.bready |=> rsp_i.bvalid)
      else $error("bvalid dropped before bready");

   rvalid_hold: assert property (@(posedge clk_i) disable iff (reset_i)
      rsp_i.rvalid && !req_i.rready |=> rsp_i.rvalid)
      else $error("rvalid dropped before rready");

   // Nothing pending right out of reset
   reset_quiet: assert property (@(posedge clk_i)
      reset_i |=> !rsp_i.bvalid && !rsp_i.rvalid)
      else $error("bus response valid right after reset");

   none_safe: assert property (@(posedge clk_i) disable iff (reset_i) none_oe == '0)
      else $error("unused pad has its output enable set");

endmodule

bind pad_ctrl_top pad_ctrl_chk u_chk (
   .clk_i    (clk_i),
   .reset_i  (reset_i),
   .req_i    (axil_req_i),
   .rsp_i    (axil_rsp_o),
   .pad_fn_i (pad_fn),
   .drive_i  (pad_drive_o)
);

// File: hdl/pad_ctrl_top.sv
// SPI pad frame controller, top level
// AXI4-Lite register block plus the combinational pad output and
// input multiplexers for the six SPI master 0 pads.

`timescale 1ns/1ps

module pad_ctrl_top (
   input  logic                                                clk_i,
   input  logic                                                reset_i,
   input  pad_ctrl_pkg::axil_req_t                             axil_req_i,
   output pad_ctrl_pkg::axil_rsp_t                             axil_rsp_o,
   input  pad_ctrl_pkg::spim_tx_t                              spim_i,
   output logic [3:0]                                          spim_sdi_o,
   input  pad_ctrl_pkg::pad_vec_t                              gpio_out_i,
   input  pad_ctrl_pkg::pad_vec_t                              gpio_dir_i,
   input  pad_ctrl_pkg::pad_cfg_t [pad_ctrl_pkg::NUM_PADS-1:0] gpio_cfg_i,
   output pad_ctrl_pkg::pad_vec_t                              gpio_in_o,
   input  logic                                                i2c1_sda_out_i,
   input  logic                                                i2c1_sda_oe_i,
   input  logic                                                i2c1_scl_out_i,
   input  logic                                                i2c1_scl_oe_i,
   output logic                                                i2c1_sda_in_o,
   output logic                                                i2c1_scl_in_o,
   input  pad_ctrl_pkg::pad_vec_t                              pad_in_i,
   output pad_ctrl_pkg::pad_drive_t                            pad_drive_o,
   output pad_ctrl_pkg::pad_cfg_t [pad_ctrl_pkg::NUM_PADS-1:0] pad_cfg_o
);

   pad_ctrl_pkg::pad_fn_t  [pad_ctrl_pkg::NUM_PADS-1:0] pad_fn;
   pad_ctrl_pkg::pad_cfg_t [pad_ctrl_pkg::NUM_PADS-1:0] reg_cfg;
   logic [3:0]                                          spi_oe;
   logic                                                spi_sdi0;

   pad_cfg_regs u_regs (
      .clk_i      (clk_i),
      .reset_i    (reset_i),
      .axil_req_i (axil_req_i),
      .axil_rsp_o (axil_rsp_o),
      .pad_fn_o   (pad_fn),
      .pad_cfg_o  (reg_cfg)
   );

   spi_pad_dir u_spi_dir (
      .mode_i    (spim_i.mode),
      .sdio_in_i (pad_in_i[pad_ctrl_pkg::PAD_SDIO3:pad_ctrl_pkg::PAD_SDIO0]),
      .oe_o      (spi_oe),
      .sdi0_o    (spi_sdi0)
   );

   pad_drive_mux u_drive (
      .pad_fn_i       (pad_fn),
      .spim_i         (spim_i),
      .spi_oe_i       (spi_oe),
      .gpio_out_i     (gpio_out_i),
      .gpio_dir_i     (gpio_dir_i),
      .gpio_cfg_i     (gpio_cfg_i),
      .reg_cfg_i      (reg_cfg),
      .i2c1_sda_out_i (i2c1_sda_out_i),
      .i2c1_sda_oe_i  (i2c1_sda_oe_i),
      .i2c1_scl_out_i (i2c1_scl_out_i),
      .i2c1_scl_oe_i  (i2c1_scl_oe_i),
      .drive_o        (pad_drive_o),
      .pad_cfg_o      (pad_cfg_o)
   );

   pad_in_route u_in (
      .pad_fn_i      (pad_fn),
      .spi_mode_i    (spim_i.mode),
      .pad_in_i      (pad_in_i),
      .spi_sdi0_i    (spi_sdi0),
      .gpio_in_o     (gpio_in_o),
      .spim_sdi_o    (spim_sdi_o),
      .i2c1_sda_in_o (i2c1_sda_in_o),
      .i2c1_scl_in_o (i2c1_scl_in_o)
   );

endmodule

// File: hdl/pad_in_route.sv
// Pad input routing
// Sends pad inputs back to GPIO, SPI master 0 and I2C1. Each input is
// gated by the function of the pad it reads and idles otherwise.

`timescale 1ns/1ps

module pad_in_route (
   input  pad_ctrl_pkg::pad_fn_t [pad_ctrl_pkg::NUM_PADS-1:0] pad_fn_i,
   input  pad_ctrl_pkg::spi_mode_t                            spi_mode_i,
   input  pad_ctrl_pkg::pad_vec_t                             pad_in_i,
   input  logic                                               spi_sdi0_i,
   output pad_ctrl_pkg::pad_vec_t                             gpio_in_o,
   output logic [3:0]                                         spim_sdi_o,
   output logic                                               i2c1_sda_in_o,
   output logic                                               i2c1_scl_in_o
);

   logic sdi0_pad_periph;

   // GPIO sees its pad only under FN_GPIO
   always_comb
   begin
      for (int n = 0; n < pad_ctrl_pkg::NUM_PADS; n++)
      begin
         gpio_in_o[n] = (pad_fn_i[n] == pad_ctrl_pkg::FN_GPIO) ? pad_in_i[n] : 1'b0;
      end
   end

   ////////////////////////////////////////////////////////////
   // SPI master 0
   ////////////////////////////////////////////////////////////
   // Input 0 follows whichever pad spi_pad_dir selected
   assign sdi0_pad_periph = (spi_mode_i == pad_ctrl_pkg::SPI_QUAD_RX) ?
                            (pad_fn_i[pad_ctrl_pkg::PAD_SDIO0] == pad_ctrl_pkg::FN_PERIPH) :
                            (pad_fn_i[pad_ctrl_pkg::PAD_SDIO1] == pad_ctrl_pkg::FN_PERIPH);

   always_comb
   begin
      spim_sdi_o[0] = sdi0_pad_periph ? spi_sdi0_i : 1'b0;
      for (int n = 1; n < 4; n++)
      begin
         spim_sdi_o[n] = (pad_fn_i[n] == pad_ctrl_pkg::FN_PERIPH) ? pad_in_i[n] : 1'b0;
      end
   end

   // I2C1 lines float high when not on their pads
   assign i2c1_sda_in_o = (pad_fn_i[pad_ctrl_pkg::PAD_SDIO2] == pad_ctrl_pkg::FN_ALT) ?
                          pad_in_i[pad_ctrl_pkg::PAD_SDIO2] : 1'b1;
   assign i2c1_scl_in_o = (pad_fn_i[pad_ctrl_pkg::PAD_SDIO3] == pad_ctrl_pkg::FN_ALT) ?
                          pad_in_i[pad_ctrl_pkg::PAD_SDIO3] : 1'b1;

endmodule

// File: hdl/pad_drive_mux.sv
// Pad output multiplexer
// Selects output value, output enable and configuration word for
// every pad from SPI master 0, GPIO, I2C1 or a fixed idle value.

`timescale 1ns/1ps

module pad_drive_mux (
   input  pad_ctrl_pkg::pad_fn_t  [pad_ctrl_pkg::NUM_PADS-1:0] pad_fn_i,
   input  pad_ctrl_pkg::spim_tx_t                              spim_i,
   input  logic [3:0]                                          spi_oe_i,
   input  pad_ctrl_pkg::pad_vec_t                              gpio_out_i,
   input  pad_ctrl_pkg::pad_vec_t                              gpio_dir_i,
   input  pad_ctrl_pkg::pad_cfg_t [pad_ctrl_pkg::NUM_PADS-1:0] gpio_cfg_i,
   input  pad_ctrl_pkg::pad_cfg_t [pad_ctrl_pkg::NUM_PADS-1:0] reg_cfg_i,
   input  logic                                                i2c1_sda_out_i,
   input  logic                                                i2c1_sda_oe_i,
   input  logic                                                i2c1_scl_out_i,
   input  logic                                                i2c1_scl_oe_i,
   output pad_ctrl_pkg::pad_drive_t                            drive_o,
   output pad_ctrl_pkg::pad_cfg_t [pad_ctrl_pkg::NUM_PADS-1:0] pad_cfg_o
);

   pad_ctrl_pkg::pad_vec_t periph_out;
   pad_ctrl_pkg::pad_vec_t periph_oe;
   pad_ctrl_pkg::pad_vec_t alt_out;
   pad_ctrl_pkg::pad_vec_t alt_oe;

   // Per-function source vectors
   always_comb
   begin
      periph_out = {spim_i.sck, spim_i.csn0, spim_i.sdo};
      periph_oe  = {2'b11, spi_oe_i};

      // Pads without an alternate user drive 0
      alt_out = '0;
      alt_oe  = '1;
      alt_out[pad_ctrl_pkg::PAD_SDIO2] = i2c1_sda_out_i;
      alt_oe[pad_ctrl_pkg::PAD_SDIO2]  = i2c1_sda_oe_i;
      alt_out[pad_ctrl_pkg::PAD_SDIO3] = i2c1_scl_out_i;
      alt_oe[pad_ctrl_pkg::PAD_SDIO3]  = i2c1_scl_oe_i;
   end

   always_comb
   begin
      for (int n = 0; n < pad_ctrl_pkg::NUM_PADS; n++)
      begin
         case (pad_fn_i[n])
            pad_ctrl_pkg::FN_PERIPH:
            begin
               drive_o.out[n] = periph_out[n];
               drive_o.oe[n]  = periph_oe[n];
            end
            pad_ctrl_pkg::FN_GPIO:
            begin
               drive_o.out[n] = gpio_out_i[n];
               drive_o.oe[n]  = gpio_dir_i[n];
            end
            pad_ctrl_pkg::FN_ALT:
            begin
               drive_o.out[n] = alt_out[n];
               drive_o.oe[n]  = alt_oe[n];
            end
            default:
            begin
               drive_o.out[n] = 1'b0;
               drive_o.oe[n]  = 1'b0;
            end
         endcase

         pad_cfg_o[n] = (pad_fn_i[n] == pad_ctrl_pkg::FN_GPIO) ? gpio_cfg_i[n] : reg_cfg_i[n];
      end
   end

endmodule

// File: hdl/spi_pad_dir.sv
// SPI master pad direction decode
// Turns the SPI mode into output enables for sdio0..3 and picks
// the pad that carries serial input 0.

`timescale 1ns/1ps

module spi_pad_dir (
   input  pad_ctrl_pkg::spi_mode_t mode_i,
   input  logic [3:0]              sdio_in_i,
   output logic [3:0]              oe_o,
   output logic                    sdi0_o
);

   // Standard TX drives sdio0 only, RX modes release all lines
   always_comb
   begin
      case (mode_i)
         pad_ctrl_pkg::SPI_STD_TX:
            oe_o = 4'b0001;
         pad_ctrl_pkg::SPI_QUAD_TX:
            oe_o = 4'b1111;
         default:
            oe_o = 4'b0000;
      endcase
   end

   // MISO sits on sdio1 in standard mode, data bit 0 on sdio0 in quad
   always_comb
   begin
      if (mode_i == pad_ctrl_pkg::SPI_QUAD_RX)
         sdi0_o = sdio_in_i[0];
      else
         sdi0_o = sdio_in_i[1];
   end

endmodule

// File: hdl/pad_cfg_regs.sv
// Pad control register block
// AXI4-Lite slave with one function-select register (2 bits per pad)
// and one configuration word per pad. Single transaction in flight.

`timescale 1ns/1ps

module pad_cfg_regs (
   input  logic                                                clk_i,
   input  logic                                                reset_i,
   input  pad_ctrl_pkg::axil_req_t                             axil_req_i,
   output pad_ctrl_pkg::axil_rsp_t                             axil_rsp_o,
   output pad_ctrl_pkg::pad_fn_t  [pad_ctrl_pkg::NUM_PADS-1:0] pad_fn_o,
   output pad_ctrl_pkg::pad_cfg_t [pad_ctrl_pkg::NUM_PADS-1:0] pad_cfg_o
);

   pad_ctrl_pkg::axil_state_e                           state_q;
   pad_ctrl_pkg::pad_fn_t  [pad_ctrl_pkg::NUM_PADS-1:0] fn_q;
   pad_ctrl_pkg::pad_cfg_t [pad_ctrl_pkg::NUM_PADS-1:0] cfg_q;
   pad_ctrl_pkg::axil_data_t                            rdata_q;
   logic [1:0]                                          resp_q;

   logic                     wr_hs;
   logic                     rd_hs;
   logic                     wr_fn_hit;
   logic                     rd_fn_hit;
   pad_ctrl_pkg::pad_vec_t   wr_cfg_hit;
   pad_ctrl_pkg::pad_vec_t   rd_cfg_hit;
   logic                     wr_ok;
   logic                     rd_ok;
   pad_ctrl_pkg::axil_data_t rd_data;

   // One-hot hit on the per-pad config words
   function automatic pad_ctrl_pkg::pad_vec_t cfg_decode(input pad_ctrl_pkg::axil_addr_t addr);
      pad_ctrl_pkg::pad_vec_t hit;
      hit = '0;
      for (int n = 0; n < pad_ctrl_pkg::NUM_PADS; n++)
      begin
         hit[n] = (addr == pad_ctrl_pkg::axil_addr_t'(pad_ctrl_pkg::ADDR_CFG0 + 4 * n));
      end
      return hit;
   endfunction

   ////////////////////////////////////////////////////////////
   // Handshake and decode
   ////////////////////////////////////////////////////////////
   // Write wins when both are offered in the same cycle
   assign wr_hs = (state_q == pad_ctrl_pkg::IDLE) & axil_req_i.awvalid & axil_req_i.wvalid;
   assign rd_hs = (state_q == pad_ctrl_pkg::IDLE) & axil_req_i.arvalid & ~wr_hs;

   assign wr_fn_hit  = (axil_req_i.awaddr == pad_ctrl_pkg::ADDR_FN);
   assign rd_fn_hit  = (axil_req_i.araddr == pad_ctrl_pkg::ADDR_FN);
   assign wr_cfg_hit = cfg_decode(axil_req_i.awaddr);
   assign rd_cfg_hit = cfg_decode(axil_req_i.araddr);
   assign wr_ok      = wr_fn_hit | (|wr_cfg_hit);
   assign rd_ok      = rd_fn_hit | (|rd_cfg_hit);

   // Read data mux, zero on a miss
   always_comb
   begin
      rd_data = '0;
      if (rd_fn_hit)
         rd_data = pad_ctrl_pkg::axil_data_t'(fn_q);
      for (int n = 0; n < pad_ctrl_pkg::NUM_PADS; n++)
      begin
         if (rd_cfg_hit[n])
            rd_data = pad_ctrl_pkg::axil_data_t'(cfg_q[n]);
      end
   end

   ////////////////////////////////////////////////////////////
   // State machine and registers
   ////////////////////////////////////////////////////////////
   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         state_q <= pad_ctrl_pkg::IDLE;
         fn_q    <= {pad_ctrl_pkg::NUM_PADS{pad_ctrl_pkg::FN_PERIPH}};
         cfg_q   <= '0;
      end
      else
      begin
         case (state_q)
            pad_ctrl_pkg::IDLE:
            begin
               if (wr_hs)
                  state_q <= pad_ctrl_pkg::WRESP;
               else if (rd_hs)
                  state_q <= pad_ctrl_pkg::RRESP;
            end
            pad_ctrl_pkg::WRESP:
            begin
               if (axil_req_i.bready)
                  state_q <= pad_ctrl_pkg::IDLE;
            end
            pad_ctrl_pkg::RRESP:
            begin
               if (axil_req_i.rready)
                  state_q <= pad_ctrl_pkg::IDLE;
            end
            default:
               state_q <= pad_ctrl_pkg::IDLE;
         endcase

         if (wr_hs & wr_fn_hit)
            fn_q <= axil_req_i.wdata[2*pad_ctrl_pkg::NUM_PADS-1:0];
         for (int n = 0; n < pad_ctrl_pkg::NUM_PADS; n++)
         begin
            if (wr_hs & wr_cfg_hit[n])
               cfg_q[n] <= pad_ctrl_pkg::pad_cfg_t'(axil_req_i.wdata);
         end
      end
   end

   // Response shared by both channels, only one is ever pending
   always_ff @(posedge clk_i)
   begin
      if (wr_hs)
         resp_q <= wr_ok ? pad_ctrl_pkg::RESP_OKAY : pad_ctrl_pkg::RESP_SLVERR;
      else if (rd_hs)
      begin
         resp_q  <= rd_ok ? pad_ctrl_pkg::RESP_OKAY : pad_ctrl_pkg::RESP_SLVERR;
         rdata_q <= rd_data;
      end
   end

   assign axil_rsp_o.awready = wr_hs;
   assign axil_rsp_o.wready  = wr_hs;
   assign axil_rsp_o.bvalid  = (state_q == pad_ctrl_pkg::WRESP);
   assign axil_rsp_o.bresp   = resp_q;
   assign axil_rsp_o.arready = rd_hs;
   assign axil_rsp_o.rvalid  = (state_q == pad_ctrl_pkg::RRESP);
   assign axil_rsp_o.rdata   = rdata_q;
   assign axil_rsp_o.rresp   = resp_q;

   assign pad_fn_o  = fn_q;
   assign pad_cfg_o = cfg_q;

endmodule

// File: hdl/pad_ctrl_pkg.sv
// Shared definitions for the SPI pad multiplexer
// Pad indices, function and SPI mode codes, AXI4-Lite bus types
// and the register map of the pad control block.

package pad_ctrl_pkg;

   // Pads
   localparam int NUM_PADS  = 6;
   localparam int PAD_SDIO0 = 0;
   localparam int PAD_SDIO1 = 1;
   localparam int PAD_SDIO2 = 2;
   localparam int PAD_SDIO3 = 3;
   localparam int PAD_CSN0  = 4;
   localparam int PAD_SCK   = 5;

   typedef logic [1:0]          pad_fn_t;
   typedef logic [1:0]          spi_mode_t;
   typedef logic [5:0]          pad_cfg_t;
   typedef logic [NUM_PADS-1:0] pad_vec_t;

   localparam pad_fn_t FN_PERIPH = 2'd0;
   localparam pad_fn_t FN_GPIO   = 2'd1;
   localparam pad_fn_t FN_ALT    = 2'd2;
   localparam pad_fn_t FN_NONE   = 2'd3;

   localparam spi_mode_t SPI_STD_TX  = 2'd0;
   localparam spi_mode_t SPI_STD_RX  = 2'd1;
   localparam spi_mode_t SPI_QUAD_TX = 2'd2;
   localparam spi_mode_t SPI_QUAD_RX = 2'd3;

   typedef struct packed {
      pad_vec_t out;
      pad_vec_t oe;
   } pad_drive_t;

   typedef struct packed {
      logic       csn0;
      logic       sck;
      logic [3:0] sdo;
      spi_mode_t  mode;
   } spim_tx_t;

   ////////////////////////////////////////////////////////////
   // AXI4-Lite
   ////////////////////////////////////////////////////////////
   localparam int AXIL_ADDR_W = 8;
   localparam int AXIL_DATA_W = 32;

   typedef logic [AXIL_ADDR_W-1:0] axil_addr_t;
   typedef logic [AXIL_DATA_W-1:0] axil_data_t;

   typedef struct packed {
      logic       awvalid;
      axil_addr_t awaddr;
      logic       wvalid;
      axil_data_t wdata;
      logic       bready;
      logic       arvalid;
      axil_addr_t araddr;
      logic       rready;
   } axil_req_t;

   typedef struct packed {
      logic       awready;
      logic       wready;
      logic       bvalid;
      logic [1:0] bresp;
      logic       arready;
      logic       rvalid;
      axil_data_t rdata;
      logic [1:0] rresp;
   } axil_rsp_t;

   localparam logic [1:0] RESP_OKAY   = 2'd0;
   localparam logic [1:0] RESP_SLVERR = 2'd2;

   // Register map, pad n config at ADDR_CFG0 + 4n
   localparam axil_addr_t ADDR_FN   = 8'h00;
   localparam axil_addr_t ADDR_CFG0 = 8'h10;

   typedef enum logic [1:0] {
      IDLE,
      WRESP,
      RRESP
   } axil_state_e;

endpackage
